/* verilog.f */
rtl/pong_pkg.sv
rtl/display_timings.sv
rtl/game_fsm.sv
rtl/paddle_ai.sv
rtl/ball_motion.sv
rtl/pixel_render.sv
rtl/pong_core.sv
tb/clock_gen_tb.sv
tb/pong_core_tb.sv

/* Makefile */
# Verilator build and run of the pong core testbench

SIM = obj_dir/Vpong_core_tb

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module pong_core_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/pong_core_tb.sv */
/*
 * pong core testbench
 * sync timing, picture, scoring and reset checks on a small screen
 */

`timescale 1ns/1ps

module pong_core_tb;

    localparam int H_RES        = 64;
    localparam int V_RES        = 48;
    localparam int H_FP         = 2;
    localparam int H_SYNC       = 4;
    localparam int H_BP         = 2;
    localparam int V_FP         = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BP         = 1;
    localparam int P_HEIGHT     = 8;
    localparam int P_WIDTH      = 2;
    localparam int P_OFFSET     = 4;
    localparam int P_SPEED      = 0;
    localparam int B_SIZE       = 2;
    localparam int B_SPX        = 3;
    localparam int B_SPY        = 2;
    localparam int SERVE_FRAMES = 2;

    localparam int H_TOTAL      = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_RES + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT      = 80 * FRAME_CYCLES;
    localparam int MAX_RALLY    = 40;  // play frames before a miss is overdue
    localparam int BALL_X0      = (H_RES - B_SIZE) / 2;
    localparam int BALL_Y0      = (V_RES - B_SIZE) / 2;
    localparam int PAD_Y        = (V_RES - P_HEIGHT) / 2;  // paddles never move
    localparam int PAD_LX       = P_OFFSET;
    localparam int PAD_RX       = H_RES - P_OFFSET - P_WIDTH;
    localparam int SEL_HSYNC    = 0;
    localparam int SEL_VSYNC    = 1;
    localparam int SEL_DE       = 2;

    logic                       clk_pix;
    logic                       rst_init;
    logic                       rst_run;  // reset raised by a test
    logic                       rst;
    logic                       start;
    logic                       hsync;
    logic                       vsync;
    logic                       de;
    logic [pong_pkg::colrw-1:0] r;
    logic [pong_pkg::colrw-1:0] g;
    logic [pong_pkg::colrw-1:0] b;
    logic [3:0]                 score_l;
    logic [3:0]                 score_r;

    int   hpos;  // where the DUT should be drawing
    int   vpos;
    int   cycles = 0;
    int   mbx;  // reference ball
    int   mby;
    logic mleft;
    logic mup;

    assign rst = rst_init || rst_run;

    clock_gen_tb clock_i (.clk_pix, .rst_init);

    pong_core #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP), .P_HEIGHT(P_HEIGHT),
        .P_WIDTH(P_WIDTH), .P_OFFSET(P_OFFSET), .P_SPEED(P_SPEED), .B_SIZE(B_SIZE),
        .B_SPX(B_SPX), .B_SPY(B_SPY), .SERVE_FRAMES(SERVE_FRAMES)
    ) pong_core_i (
        .clk_pix, .rst, .start, .hsync, .vsync, .de, .r, .g, .b, .score_l, .score_r
    );

    always @(posedge clk_pix) begin
        if (rst) begin
            hpos <= 0;
            vpos <= 0;
        end else if (hpos == H_TOTAL - 1) begin
            hpos <= 0;
            vpos <= (vpos == V_TOTAL - 1) ? 0 : vpos + 1;
        end else begin
            hpos <= hpos + 1;
        end
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input int expected, input int actual, input string what);
        if (actual != expected) begin
            $display("error at %0t ns: %s, expected %0d, got %0d",
                     $time, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_scores(input int left, input int right, input string when);
        check_value(left, int'(score_l), {"left score ", when});
        check_value(right, int'(score_r), {"right score ", when});
    endtask

    function automatic logic in_box(input int x, input int y, input int x0, input int y0,
                                    input int w, input int h);
        return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
    endfunction

    // all channels full on an object, black elsewhere and in blanking
    function automatic int expected_rgb(input int x, input int y,
                                        input int ball_x, input int ball_y);
        logic lit;
        lit = in_box(x, y, ball_x, ball_y, B_SIZE, B_SIZE) ||
              in_box(x, y, PAD_LX, PAD_Y, P_WIDTH, P_HEIGHT) ||
              in_box(x, y, PAD_RX, PAD_Y, P_WIDTH, P_HEIGHT);
        if (x >= H_RES || y >= V_RES) begin
            lit = 1'b0;
        end
        return lit ? 'hfff : 0;
    endfunction

    function automatic logic ball_on_paddle(input int pad_x);
        return (mbx < pad_x + P_WIDTH) && (pad_x < mbx + B_SIZE) &&
               (mby < PAD_Y + P_HEIGHT) && (PAD_Y < mby + B_SIZE);
    endfunction

    // one frame of the reference ball: 0 rally goes on, 1 left miss, 2 right miss
    function automatic int ball_step();
        logic hit_l;
        logic hit_r;
        hit_l = ball_on_paddle(PAD_LX);
        hit_r = ball_on_paddle(PAD_RX);
        if (!hit_l && !hit_r && mbx < B_SPX) begin
            return 1;
        end
        if (!hit_l && !hit_r && mbx >= H_RES - B_SPX - B_SIZE) begin
            return 2;
        end
        if (hit_l) begin
            mleft = 1'b0;
        end else if (hit_r) begin
            mleft = 1'b1;
        end
        if (mby >= V_RES - B_SPY - B_SIZE) begin  // bottom wall
            mup = 1'b1;
        end else if (mby < B_SPY) begin
            mup = 1'b0;
        end
        mbx = mleft ? mbx - B_SPX : mbx + B_SPX;
        mby = mup ? mby - B_SPY : mby + B_SPY;
        return 0;
    endfunction

    function automatic logic port_level(input int sel);
        case (sel)
            SEL_HSYNC: return hsync;
            SEL_VSYNC: return vsync;
            default:   return de;
        endcase
    endfunction

    // call at a falling clock edge, returns at the first sample that differs
    task automatic count_while(input int sel, input logic level, output int n);
        n = 0;
        while (port_level(sel) == level) begin
            n++;
            @(negedge clk_pix);
        end
    endtask

    // every cycle of one frame from the origin, ball drawn at the given place
    task automatic scan_frame(input int ball_x, input int ball_y);
        int n;
        @(negedge clk_pix);
        while (hpos != 0 || vpos != 0) begin
            @(negedge clk_pix);
        end
        for (n = 0; n < FRAME_CYCLES; n++) begin
            if (n != 0) begin
                @(negedge clk_pix);
            end
            check_value(int'(hpos < H_RES && vpos < V_RES), int'(de),
                        $sformatf("de at (%0d,%0d)", hpos, vpos));
            check_value(expected_rgb(hpos, vpos, ball_x, ball_y), int'({r, g, b}),
                        $sformatf("rgb at (%0d,%0d)", hpos, vpos));
        end
    endtask

    task automatic test_sync_timing;
        int skip;
        int low;
        int high;
        int act;
        int vlow;
        int vhigh;
        @(negedge clk_pix);
        count_while(SEL_HSYNC, 1'b0, skip);
        count_while(SEL_HSYNC, 1'b1, skip);  // now at a falling edge
        count_while(SEL_HSYNC, 1'b0, low);
        count_while(SEL_HSYNC, 1'b1, high);
        check_value(H_SYNC, low, "hsync low width");
        check_value(H_TOTAL, low + high, "cycles between hsync falling edges");
        count_while(SEL_DE, 1'b1, skip);
        count_while(SEL_DE, 1'b0, skip);
        count_while(SEL_DE, 1'b1, act);
        check_value(H_RES, act, "active cycles per line");
        count_while(SEL_VSYNC, 1'b0, skip);
        count_while(SEL_VSYNC, 1'b1, skip);
        count_while(SEL_VSYNC, 1'b0, vlow);
        count_while(SEL_VSYNC, 1'b1, vhigh);
        check_value(V_SYNC * H_TOTAL, vlow, "vsync low cycles");
        check_value(0, (vlow + vhigh) % H_TOTAL, "frame length in whole lines");
        check_value(V_TOTAL, (vlow + vhigh) / H_TOTAL, "lines per frame");
    endtask

    task automatic test_idle_picture;
        scan_frame(BALL_X0, BALL_Y0);
        check_scores(0, 0, "in idle");
    endtask

    task automatic test_idle_holds;
        repeat (5) begin
            scan_frame(BALL_X0, BALL_Y0);
            check_scores(0, 0, "while idle");
        end
    endtask

    task automatic test_serve_point;
        int n;
        int side;
        @(posedge clk_pix);
        start <= 1'b1;
        // strobe into serve plus the serve delay, ball parked at centre
        for (n = 0; n < SERVE_FRAMES + 1; n++) begin
            scan_frame(BALL_X0, BALL_Y0);
            check_scores(0, 0, "during serve");
        end
        mbx   = BALL_X0;
        mby   = BALL_Y0;
        mleft = 1'b0;  // right and down after reset
        mup   = 1'b0;
        side  = 0;
        n     = 0;
        while (side == 0 && n < MAX_RALLY) begin
            scan_frame(mbx, mby);
            side = ball_step();
            n++;
            check_scores(side == 2 ? 1 : 0, side == 1 ? 1 : 0, "after a play frame");
        end
        if (side == 0) begin
            $display("the reference ball found no miss within %0d play frames", MAX_RALLY);
            $display("ERRORS FOUND");
            $fatal(1, "rally never ended");
        end else begin
            $display("ball missed on the %s side in play frame %0d",
                     side == 1 ? "left" : "right", n);
            for (n = 0; n < SERVE_FRAMES + 1; n++) begin  // point frame then serve
                scan_frame(BALL_X0, BALL_Y0);
                check_scores(side == 2 ? 1 : 0, side == 1 ? 1 : 0, "after the point");
            end
        end
    endtask

    task automatic test_reset_mid_game;
        repeat (20 * H_TOTAL) @(posedge clk_pix);  // well inside a play frame
        rst_run <= 1'b1;
        start   <= 1'b0;
        repeat (10) @(posedge clk_pix);
        rst_run <= 1'b0;
        @(negedge clk_pix);
        check_scores(0, 0, "after reset");
        scan_frame(BALL_X0, BALL_Y0);
        check_scores(0, 0, "in idle after reset");
    endtask

    initial begin
        start   = 1'b0;
        rst_run = 1'b0;
        @(negedge clk_pix);
        while (rst) begin
            @(negedge clk_pix);
        end
        test_sync_timing();
        test_idle_picture();
        test_idle_holds();
        test_serve_point();
        test_reset_mid_game();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tb/clock_gen_tb.sv */
/*
 * testbench clock and power-on reset
 * 100 ns pixel clock, reset held for the first 10 cycles
 */

`timescale 1ns/1ps

module clock_gen_tb #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_pix,
    output logic rst_init
);

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;  // 100 ns period
    end

    initial begin
        rst_init = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_pix);
        rst_init <= 1'b0;
    end

endmodule

/* rtl/pong_core.sv */
/*
 * pong core top level
 * joins timing, sequencer, paddles, ball and renderer
 */

`timescale 1ns/1ps

module pong_core #(
    parameter int H_RES        = 640,
    parameter int V_RES        = 480,
    parameter int H_FP         = 16,
    parameter int H_SYNC       = 96,
    parameter int H_BP         = 48,
    parameter int V_FP         = 10,
    parameter int V_SYNC       = 2,
    parameter int V_BP         = 33,
    parameter int P_HEIGHT     = 40,
    parameter int P_WIDTH      = 10,
    parameter int P_OFFSET     = 32,
    parameter int P_SPEED      = 4,
    parameter int B_SIZE       = 8,
    parameter int B_SPX        = 6,
    parameter int B_SPY        = 4,
    parameter int SERVE_FRAMES = 60
) (
    input  logic                       clk_pix,
    input  logic                       rst,
    input  logic                       start,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       de,
    output logic [pong_pkg::colrw-1:0] r,
    output logic [pong_pkg::colrw-1:0] g,
    output logic [pong_pkg::colrw-1:0] b,
    output logic [3:0]                 score_l,
    output logic [3:0]                 score_r
);

    logic [pong_pkg::cordw-1:0] sx, sy;
    logic [pong_pkg::cordw-1:0] bx, by;
    logic [pong_pkg::cordw-1:0] p1y, p2y;
    logic                       frame;  // one tick at start of blanking
    logic                       col_l, col_r;
    logic                       miss_l, miss_r;
    pong_pkg::game_state_t      state;

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timings_i (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame
    );

    game_fsm #(.SERVE_FRAMES(SERVE_FRAMES)) fsm_i (
        .clk_pix, .rst, .frame, .start, .miss_l, .miss_r, .state, .score_l, .score_r
    );

    paddle_ai #(
        .V_RES(V_RES), .P_HEIGHT(P_HEIGHT), .P_SPEED(P_SPEED), .B_SIZE(B_SIZE)
    ) paddles_i (
        .clk_pix, .rst, .frame, .by, .p1y, .p2y
    );

    ball_motion #(
        .H_RES(H_RES), .V_RES(V_RES), .P_HEIGHT(P_HEIGHT), .P_WIDTH(P_WIDTH),
        .P_OFFSET(P_OFFSET), .B_SIZE(B_SIZE), .B_SPX(B_SPX), .B_SPY(B_SPY)
    ) ball_i (
        .clk_pix, .rst, .frame, .col_l, .col_r, .state, .bx, .by, .miss_l, .miss_r
    );

    pixel_render #(
        .H_RES(H_RES), .P_HEIGHT(P_HEIGHT), .P_WIDTH(P_WIDTH), .P_OFFSET(P_OFFSET),
        .B_SIZE(B_SIZE)
    ) render_i (
        .clk_pix, .rst, .frame, .de, .sx, .sy, .bx, .by, .p1y, .p2y,
        .col_l, .col_r, .r, .g, .b
    );

endmodule

/* rtl/pixel_render.sv */
/*
 * pixel renderer
 * ball and paddle hit tests, collision flags and monochrome colour
 */

`timescale 1ns/1ps

module pixel_render #(
    parameter int H_RES    = 640,
    parameter int P_HEIGHT = 40,
    parameter int P_WIDTH  = 10,
    parameter int P_OFFSET = 32,
    parameter int B_SIZE   = 8
) (
    input  logic                       clk_pix,
    input  logic                       rst,
    input  logic                       frame,
    input  logic                       de,
    input  logic [pong_pkg::cordw-1:0] sx,
    input  logic [pong_pkg::cordw-1:0] sy,
    input  logic [pong_pkg::cordw-1:0] bx,
    input  logic [pong_pkg::cordw-1:0] by,
    input  logic [pong_pkg::cordw-1:0] p1y,
    input  logic [pong_pkg::cordw-1:0] p2y,
    output logic                       col_l,
    output logic                       col_r,
    output logic [pong_pkg::colrw-1:0] r,
    output logic [pong_pkg::colrw-1:0] g,
    output logic [pong_pkg::colrw-1:0] b
);

    localparam int CW = pong_pkg::cordw;
    localparam logic [CW-1:0] PL_BEG = CW'(P_OFFSET);
    localparam logic [CW-1:0] PL_END = CW'(P_OFFSET + P_WIDTH);
    localparam logic [CW-1:0] PR_BEG = CW'(H_RES - P_OFFSET - P_WIDTH);
    localparam logic [CW-1:0] PR_END = CW'(H_RES - P_OFFSET);
    localparam logic [CW-1:0] PH     = CW'(P_HEIGHT);
    localparam logic [CW-1:0] BS     = CW'(B_SIZE);

    logic b_hit;
    logic p1_hit;
    logic p2_hit;
    logic lit;

    always_comb begin
        b_hit  = (sx >= bx) && (sx < bx + BS) && (sy >= by) && (sy < by + BS);
        p1_hit = (sx >= PL_BEG) && (sx < PL_END) && (sy >= p1y) && (sy < p1y + PH);
        p2_hit = (sx >= PR_BEG) && (sx < PR_END) && (sy >= p2y) && (sy < p2y + PH);
        lit    = de && (b_hit || p1_hit || p2_hit);
        r      = lit ? {pong_pkg::colrw{1'b1}} : '0;
        g      = lit ? {pong_pkg::colrw{1'b1}} : '0;
        b      = lit ? {pong_pkg::colrw{1'b1}} : '0;
    end

    // flags collected over one frame, read by the ball at the next strobe
    always_ff @(posedge clk_pix) begin
        if (rst || frame) begin
            col_l <= 1'b0;
            col_r <= 1'b0;
        end else if (b_hit) begin
            if (p1_hit) col_l <= 1'b1;
            if (p2_hit) col_r <= 1'b1;
        end
    end

endmodule

/* rtl/ball_motion.sv */
/*
 * ball motion
 * position and direction update per frame with bounces and miss detection
 */

`timescale 1ns/1ps

module ball_motion #(
    parameter int H_RES    = 640,
    parameter int V_RES    = 480,
    parameter int P_HEIGHT = 40,
    parameter int P_WIDTH  = 10,
    parameter int P_OFFSET = 32,
    parameter int B_SIZE   = 8,
    parameter int B_SPX    = 6,
    parameter int B_SPY    = 4
) (
    input  logic                       clk_pix,
    input  logic                       rst,
    input  logic                       frame,
    input  logic                       col_l,
    input  logic                       col_r,
    input  pong_pkg::game_state_t      state,
    output logic [pong_pkg::cordw-1:0] bx,
    output logic [pong_pkg::cordw-1:0] by,
    output logic                       miss_l,
    output logic                       miss_r
);

    localparam int CW = pong_pkg::cordw;
    localparam logic [CW-1:0] X_MID = CW'((H_RES - B_SIZE) / 2);
    localparam logic [CW-1:0] Y_MID = CW'((V_RES - B_SIZE) / 2);
    localparam logic [CW-1:0] SPX   = CW'(B_SPX);
    localparam logic [CW-1:0] SPY   = CW'(B_SPY);
    localparam logic [CW-1:0] X_MAX = CW'(H_RES - B_SPX - B_SIZE);  // right edge limit
    localparam logic [CW-1:0] Y_MAX = CW'(V_RES - B_SPY - B_SIZE);

    logic dx;  // 1 moves left
    logic dy;  // 1 moves up
    logic out_l;
    logic out_r;

    always_comb begin
        out_l = !col_l && !col_r && (bx < SPX);
        out_r = !col_l && !col_r && (bx >= X_MAX);
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            bx     <= X_MID;
            by     <= Y_MID;
            dx     <= 1'b0;
            dy     <= 1'b0;
            miss_l <= 1'b0;
            miss_r <= 1'b0;
        end else begin
            miss_l <= 1'b0;
            miss_r <= 1'b0;
            if (frame) begin
                if (state != pong_pkg::PLAY) begin  // held at centre
                    bx <= X_MID;
                    by <= Y_MID;
                end else if (out_l || out_r) begin
                    bx     <= X_MID;
                    by     <= Y_MID;
                    dx     <= out_l;  // serve toward the side that lost
                    miss_l <= out_l;
                    miss_r <= out_r;
                end else begin
                    if (col_l) begin
                        dx <= 1'b0;
                        bx <= bx + SPX;
                    end else if (col_r) begin
                        dx <= 1'b1;
                        bx <= bx - SPX;
                    end else begin
                        bx <= dx ? bx - SPX : bx + SPX;
                    end

                    if (by >= Y_MAX) begin  // bottom edge
                        dy <= 1'b1;
                        by <= by - SPY;
                    end else if (by < SPY) begin  // top edge
                        dy <= 1'b0;
                        by <= by + SPY;
                    end else begin
                        by <= dy ? by - SPY : by + SPY;
                    end
                end
            end
        end
    end

endmodule

/* rtl/paddle_ai.sv */
/*
 * paddle tracking for both sides
 * each paddle steps toward the ball centre once per frame
 */

`timescale 1ns/1ps

module paddle_ai #(
    parameter int V_RES    = 480,
    parameter int P_HEIGHT = 40,
    parameter int P_SPEED  = 4,
    parameter int B_SIZE   = 8
) (
    input  logic                       clk_pix,
    input  logic                       rst,
    input  logic                       frame,
    input  logic [pong_pkg::cordw-1:0] by,
    output logic [pong_pkg::cordw-1:0] p1y,
    output logic [pong_pkg::cordw-1:0] p2y
);

    localparam int CW = pong_pkg::cordw;
    localparam logic [CW-1:0] P_MID  = CW'((V_RES - P_HEIGHT) / 2);
    localparam logic [CW-1:0] P_MAX  = CW'(V_RES - P_HEIGHT);  // lowest top row
    localparam logic [CW-1:0] SPD    = CW'(P_SPEED);
    localparam logic [CW:0]   P_HALF = (CW + 1)'(P_HEIGHT / 2);
    localparam logic [CW:0]   B_HALF = (CW + 1)'(B_SIZE / 2);

    // one step of the tracking rule, clamped to the screen
    function automatic logic [CW-1:0] track(input logic [CW-1:0] py,
                                            input logic [CW-1:0] ball_y);
        logic [CW:0] pad_mid;
        logic [CW:0] ball_mid;
        pad_mid  = {1'b0, py} + P_HALF;
        ball_mid = {1'b0, ball_y} + B_HALF;
        track    = py;
        if (pad_mid < ball_mid) begin  // ball below
            track = (py + SPD <= P_MAX) ? py + SPD : P_MAX;
        end else if (pad_mid > ball_mid) begin  // ball above
            track = (py >= SPD) ? py - SPD : '0;
        end
    endfunction

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            p1y <= P_MID;
            p2y <= P_MID;
        end else if (frame) begin
            p1y <= track(p1y, by);
            p2y <= track(p2y, by);
        end
    end

endmodule

/* rtl/game_fsm.sv */
/*
 * game sequencer
 * idle, serve delay, play and point states with both score counters
 */

`timescale 1ns/1ps

module game_fsm #(
    parameter int SERVE_FRAMES = 60
) (
    input  logic                  clk_pix,
    input  logic                  rst,
    input  logic                  frame,
    input  logic                  start,
    input  logic                  miss_l,
    input  logic                  miss_r,
    output pong_pkg::game_state_t state,
    output logic [3:0]            score_l,
    output logic [3:0]            score_r
);

    localparam int SW = $clog2(SERVE_FRAMES + 1);
    localparam logic [SW-1:0] SERVE_LAST = SW'(SERVE_FRAMES - 1);

    logic [SW-1:0] serve_cnt;  // frames spent in serve

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state     <= pong_pkg::IDLE;
            serve_cnt <= '0;
            score_l   <= '0;
            score_r   <= '0;
        end else begin
            case (state)
                pong_pkg::IDLE: begin
                    if (frame && start) begin
                        state     <= pong_pkg::SERVE;
                        serve_cnt <= '0;
                    end
                end
                pong_pkg::SERVE: begin
                    if (frame) begin
                        if (serve_cnt == SERVE_LAST) begin
                            state <= pong_pkg::PLAY;
                        end else begin
                            serve_cnt <= serve_cnt + 1'b1;
                        end
                    end
                end
                pong_pkg::PLAY: begin
                    if (miss_l) begin  // left missed, point to right
                        score_r <= score_r + 1'b1;
                        state   <= pong_pkg::POINT;
                    end else if (miss_r) begin
                        score_l <= score_l + 1'b1;
                        state   <= pong_pkg::POINT;
                    end
                end
                default: begin  // POINT
                    if (frame) begin
                        state     <= pong_pkg::SERVE;
                        serve_cnt <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/display_timings.sv */
/*
 * display timing generator
 * pixel and line counters with sync, data enable and frame strobe
 */

`timescale 1ns/1ps

module display_timings #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic                       clk_pix,
    input  logic                       rst,
    output logic [pong_pkg::cordw-1:0] sx,
    output logic [pong_pkg::cordw-1:0] sy,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       de,
    output logic                       frame
);

    localparam int CW = pong_pkg::cordw;
    localparam logic [CW-1:0] H_LAST = CW'(H_RES + H_FP + H_SYNC + H_BP - 1);
    localparam logic [CW-1:0] V_LAST = CW'(V_RES + V_FP + V_SYNC + V_BP - 1);
    localparam logic [CW-1:0] HA_END = CW'(H_RES);
    localparam logic [CW-1:0] VA_END = CW'(V_RES);
    localparam logic [CW-1:0] HS_BEG = CW'(H_RES + H_FP);
    localparam logic [CW-1:0] HS_END = CW'(H_RES + H_FP + H_SYNC);
    localparam logic [CW-1:0] VS_BEG = CW'(V_RES + V_FP);
    localparam logic [CW-1:0] VS_END = CW'(V_RES + V_FP + V_SYNC);

    logic [CW-1:0] sx_nxt;
    logic [CW-1:0] sy_nxt;

    always_comb begin
        if (sx == H_LAST) begin  // line end
            sx_nxt = '0;
            sy_nxt = (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx_nxt = sx + 1'b1;
            sy_nxt = sy;
        end
    end

    // decode from the next count so every output lines up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b1;
            frame <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= !((sx_nxt >= HS_BEG) && (sx_nxt < HS_END));  // active low
            vsync <= !((sy_nxt >= VS_BEG) && (sy_nxt < VS_END));
            de    <= (sx_nxt < HA_END) && (sy_nxt < VA_END);
            frame <= (sy_nxt == VA_END) && (sx_nxt == '0);  // start of vertical blanking
        end
    end

endmodule

/* rtl/pong_pkg.sv */
/*
 * pong shared definitions
 * coordinate and colour widths, game sequencer states
 */

package pong_pkg;

    parameter int cordw = 10;  // screen coordinate width
    parameter int colrw = 4;   // one colour channel

    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // waiting for start
        PLAY  = 2'd1,  // ball in motion
        POINT = 2'd2,  // a side just missed
        SERVE = 2'd3   // ball held at centre before play
    } game_state_t;

endpackage
